//--- rtl/isa_pkg.sv
package isa_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // opcode byte layout aaabbbcc
    typedef struct packed {
        logic [2:0] op_a;   // operation within the group
        logic [2:0] op_b;   // addressing mode
        logic [1:0] op_c;   // group
    } opcode_t;

    // groups selected by op_c
    typedef enum logic [1:0] {
        GRP_CTRL = 2'd0,
        GRP_ACC  = 2'd1,
        GRP_RMW  = 2'd2
    } group_e;

    // op_b modes kept for the accumulator group
    typedef enum logic [2:0] {
        AM_ZPG = 3'd1,
        AM_IMM = 3'd2,
        AM_ABS = 3'd3
    } amode_e;

    // op_a in the accumulator group
    typedef enum logic [2:0] {
        OP_ORA,
        OP_AND,
        OP_EOR,
        OP_ADC,
        OP_STA,
        OP_LDA,
        OP_CMP,
        OP_SBC
    } acc_op_e;

    localparam int FLAG_C = 0;  // carry bit of P

    localparam logic [DATA_W-1:0] OPC_NOP = 8'hea;
    localparam logic [DATA_W-1:0] OPC_JMP = 8'h4c;  // jmp abs
    localparam logic [DATA_W-1:0] OPC_CLC = 8'h18;
    localparam logic [DATA_W-1:0] OPC_SEC = 8'h38;

endpackage

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [isa_pkg::DATA_W-1:0] data_t;
    typedef logic [isa_pkg::ADDR_W-1:0] addr_t;

    typedef enum logic [3:0] {
        T_BOOT,
        T0_FETCH,
        T1_DECODE,
        T2_ZPG,
        T2_ABS,
        T3_ABS,
        T2_JMP,
        T3_JMP,
        T_JAM
    } state_e;

    typedef enum logic [1:0] {DB_DATA, DB_Z} db_src_e;
    typedef enum logic [1:0] {SB_A, SB_Z} sb_src_e;
    typedef enum logic [1:0] {RES_DB, RES_SB, RES_ADD} res_src_e;
    typedef enum logic [1:0] {DST_A, DST_MEM, DST_NONE} res_dst_e;
    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;
    typedef enum logic [1:0] {CIN_0, CIN_1, CIN_P} carry_sel_e;
    typedef enum logic [1:0] {ADR_PC, ADR_ZPG, ADR_ABS, ADR_HOLD} addr_sel_e;

    // per-instruction control, latched at decode
    typedef struct packed {
        db_src_e    db_src;
        sb_src_e    sb_src;
        res_src_e   res_src;
        res_dst_e   res_dst;
        alu_op_e    alu_op;
        logic       inv_bi;
        carry_sel_e carry_sel;
        logic       write_c;
    } exec_ctrl_t;

    // per-cycle control into the datapath
    typedef struct packed {
        db_src_e    db_src;
        sb_src_e    sb_src;
        res_src_e   res_src;
        res_dst_e   res_dst;
        alu_op_e    alu_op;
        logic       inv_bi;
        carry_sel_e carry_sel;
        logic       write_c;
        addr_sel_e  addr_sel;
        logic       pc_inc;
        logic       jump;
    } bus_ctrl_t;

    localparam exec_ctrl_t EX_IDLE = '{db_src: DB_Z, sb_src: SB_Z, res_src: RES_ADD,
                                       res_dst: DST_NONE, alu_op: ALU_ADD, inv_bi: 1'b0,
                                       carry_sel: CIN_0, write_c: 1'b0};

endpackage

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::data_t   i_a,
    input  cpu_pkg::data_t   i_b,
    input  logic             i_ci,
    input  cpu_pkg::alu_op_e i_op,
    output cpu_pkg::data_t   o_y,
    output logic             o_co
);
    import cpu_pkg::*;

    logic [8:0] sum;

    always_comb begin
        sum  = {1'b0, i_a} + {1'b0, i_b} + {8'h00, i_ci};
        o_co = 1'b0;    // logic ops leave carry clear

        case (i_op)
            ALU_ADD: begin
                o_y  = sum[7:0];
                o_co = sum[8];
            end
            ALU_AND: o_y = i_a & i_b;
            ALU_OR:  o_y = i_a | i_b;
            default: o_y = i_a ^ i_b;
        endcase
    end

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                i_clk,
    input  logic                i_rst,
    input  cpu_pkg::data_t      i_data,
    input  cpu_pkg::state_e     i_state,
    output cpu_pkg::exec_ctrl_t o_ex,
    output cpu_pkg::state_e     o_mode,
    output logic                o_single_byte
);
    import isa_pkg::*;
    import cpu_pkg::*;

    data_t      din;    // byte fetched in the previous cycle
    opcode_t    ir;
    opcode_t    op;
    exec_ctrl_t ex_d;

    always_ff @(posedge i_clk) begin
        din <= i_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ir <= OPC_NOP;
        end else if (i_state == T1_DECODE) begin
            ir <= din;
        end
    end

    // new opcode is used straight away while decoding
    assign op = (i_state == T1_DECODE) ? din : ir;

    // first state after decode, from the opcode layout
    always_comb begin
        o_mode        = T_JAM;
        o_single_byte = 1'b0;
        if (op == OPC_JMP) begin
            o_mode = T2_JMP;
        end else if (op == OPC_CLC || op == OPC_SEC || op == OPC_NOP) begin
            o_mode        = T0_FETCH;
            o_single_byte = 1'b1;
        end else if (op.op_c == GRP_ACC) begin
            case (op.op_b)
                AM_ZPG:  o_mode = T2_ZPG;
                AM_IMM:  o_mode = (op.op_a == OP_STA) ? T_JAM : T0_FETCH;
                AM_ABS:  o_mode = T2_ABS;
                default: o_mode = T_JAM;    // indexed and indirect modes
            endcase
        end
    end

    always_comb begin
        // A + mem -> A unless the op says otherwise
        ex_d.db_src    = DB_DATA;
        ex_d.sb_src    = SB_A;
        ex_d.res_src   = RES_ADD;
        ex_d.res_dst   = DST_A;
        ex_d.alu_op    = ALU_ADD;
        ex_d.inv_bi    = 1'b0;
        ex_d.carry_sel = CIN_0;
        ex_d.write_c   = 1'b0;

        if (op.op_c == GRP_ACC) begin
            case (acc_op_e'(op.op_a))
                OP_ORA: ex_d.alu_op = ALU_OR;
                OP_AND: ex_d.alu_op = ALU_AND;
                OP_EOR: ex_d.alu_op = ALU_XOR;
                OP_ADC: begin
                    ex_d.carry_sel = CIN_P;
                    ex_d.write_c   = 1'b1;
                end
                OP_STA: begin
                    ex_d.res_src = RES_SB;
                    ex_d.res_dst = DST_MEM;
                end
                OP_LDA: ex_d.res_src = RES_DB;
                OP_CMP: begin
                    ex_d.inv_bi    = 1'b1;  // A - mem, borrow clear
                    ex_d.carry_sel = CIN_1;
                    ex_d.write_c   = 1'b1;
                    ex_d.res_dst   = DST_NONE;
                end
                default: begin              // SBC
                    ex_d.inv_bi    = 1'b1;
                    ex_d.carry_sel = CIN_P;
                    ex_d.write_c   = 1'b1;
                end
            endcase
        end else begin
            ex_d = EX_IDLE;
            // clc adds 0+0+0, sec adds 0+ff+1, carry out is the flag
            if (op == OPC_CLC || op == OPC_SEC) begin
                ex_d.write_c = 1'b1;
            end
            if (op == OPC_SEC) begin
                ex_d.inv_bi    = 1'b1;
                ex_d.carry_sel = CIN_1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex <= EX_IDLE;
        end else begin
            o_ex <= ex_d;
        end
    end

endmodule

//--- rtl/sequencer.sv
`timescale 1ns/1ps

module sequencer (
    input  logic                i_clk,
    input  logic                i_rst,
    input  cpu_pkg::exec_ctrl_t i_ex,
    input  cpu_pkg::state_e     i_mode,
    input  logic                i_single_byte,
    output cpu_pkg::state_e     o_state,
    output cpu_pkg::bus_ctrl_t  o_bus
);
    import cpu_pkg::*;

    state_e state;
    logic   rd_op, ld_op, st_op;
    logic   compute_result, save_result;

    assign o_state = state;

    // memory pattern of the op in flight
    always_comb begin
        st_op = (i_ex.res_dst == DST_MEM);
        ld_op = !st_op && (i_ex.res_src == RES_DB);
        rd_op = !st_op && !ld_op;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= T_BOOT;
        end else begin
            case (state)
                T_BOOT:    state <= T0_FETCH;
                T0_FETCH:  state <= T1_DECODE;
                T1_DECODE: state <= i_mode;
                T2_ZPG:    state <= T0_FETCH;
                T2_ABS:    state <= T3_ABS;
                T3_ABS:    state <= T0_FETCH;
                T2_JMP:    state <= T3_JMP;
                T3_JMP:    state <= T1_DECODE;   // target opcode already read
                default:   state <= T_JAM;
            endcase
        end
    end

    always_comb begin
        compute_result = 1'b0;
        save_result    = 1'b0;

        // idle alu passes the fetched byte into add
        o_bus.db_src    = DB_DATA;
        o_bus.sb_src    = SB_Z;
        o_bus.res_src   = RES_ADD;
        o_bus.res_dst   = DST_NONE;
        o_bus.alu_op    = ALU_ADD;
        o_bus.inv_bi    = 1'b0;
        o_bus.carry_sel = CIN_0;
        o_bus.write_c   = 1'b0;
        o_bus.addr_sel  = ADR_PC;
        o_bus.pc_inc    = 1'b0;
        o_bus.jump      = 1'b0;

        case (state)
            T0_FETCH: begin
                o_bus.pc_inc   = 1'b1;
                compute_result = rd_op;
                save_result    = ld_op;
            end
            T1_DECODE: begin
                o_bus.pc_inc = !i_single_byte;
                save_result  = rd_op;   // write back while next op decodes
            end
            T2_ZPG: begin
                o_bus.addr_sel = ADR_ZPG;
                save_result    = st_op;
            end
            T2_ABS, T2_JMP: o_bus.pc_inc = 1'b1;    // fetch high byte
            T3_ABS: begin
                o_bus.addr_sel = ADR_ABS;
                save_result    = st_op;
            end
            T3_JMP: begin
                o_bus.addr_sel = ADR_ABS;
                o_bus.jump     = 1'b1;
            end
            T_JAM: o_bus.addr_sel = ADR_HOLD;       // bus frozen
            default: begin
            end
        endcase

        if (compute_result || save_result) begin
            o_bus.db_src = i_ex.db_src;
            o_bus.sb_src = i_ex.sb_src;
        end
        if (compute_result) begin
            o_bus.alu_op    = i_ex.alu_op;
            o_bus.inv_bi    = i_ex.inv_bi;
            o_bus.carry_sel = i_ex.carry_sel;
            o_bus.write_c   = i_ex.write_c;
        end
        if (save_result) begin
            o_bus.res_src = i_ex.res_src;
            o_bus.res_dst = i_ex.res_dst;
        end
    end

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter cpu_pkg::addr_t BOOT_ADDR = 16'h0000
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  cpu_pkg::data_t     i_data,
    input  cpu_pkg::bus_ctrl_t i_bus,
    output cpu_pkg::addr_t     o_addr,
    output cpu_pkg::data_t     o_dout,
    output logic               o_rw
);
    import isa_pkg::*;
    import cpu_pkg::*;

    data_t      a, dl, add;
    logic [FLAG_C:FLAG_C] p;    // carry is the only flag
    addr_t      pc, pcsel, nextpc, radr;

    data_t db, sb, res;     // data, register and result buses
    data_t bi, alu_y;
    logic  ci, alu_co;

    // jump loads the target, then steps past the opcode being read
    assign pcsel  = i_bus.jump ? o_addr : pc;
    assign nextpc = (i_bus.pc_inc || i_bus.jump) ? pcsel + 16'd1 : pcsel;

    always_comb begin
        case (i_bus.addr_sel)
            ADR_PC:  o_addr = pc;
            ADR_ZPG: o_addr = {8'h00, dl};
            ADR_ABS: o_addr = {dl, add};    // high byte on the bus, low byte held in add
            default: o_addr = radr;
        endcase
    end

    always_comb begin
        db  = (i_bus.db_src == DB_DATA) ? dl : 8'h00;
        sb  = (i_bus.sb_src == SB_A) ? a : 8'h00;
        case (i_bus.res_src)
            RES_DB:  res = db;
            RES_SB:  res = sb;
            RES_ADD: res = add;
            default: res = 8'h00;
        endcase

        bi = i_bus.inv_bi ? ~db : db;
        case (i_bus.carry_sel)
            CIN_1:   ci = 1'b1;
            CIN_P:   ci = p[FLAG_C];
            default: ci = 1'b0;
        endcase
    end

    alu alu_i (
        .i_a  (sb),
        .i_b  (bi),
        .i_ci (ci),
        .i_op (i_bus.alu_op),
        .o_y  (alu_y),
        .o_co (alu_co)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            a  <= 8'h00;
            p  <= '0;
            pc <= BOOT_ADDR;
        end else begin
            pc <= nextpc;
            if (i_bus.res_dst == DST_A) a <= res;
            if (i_bus.write_c) p[FLAG_C] <= alu_co;
        end
    end

    always_ff @(posedge i_clk) begin
        dl   <= i_data;     // memory byte for the next cycle
        add  <= alu_y;
        radr <= o_addr;
    end

    assign o_rw   = (i_bus.res_dst != DST_MEM);
    assign o_dout = o_rw ? 8'h00 : res;

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::addr_t BOOT_ADDR = 16'h0000
) (
    input  logic           i_clk,
    input  logic           i_rst,
    input  cpu_pkg::data_t i_data,
    output cpu_pkg::addr_t o_addr,
    output cpu_pkg::data_t o_dout,
    output logic           o_rw
);
    import cpu_pkg::*;

    exec_ctrl_t ex;
    state_e     mode;
    state_e     state;
    logic       single_byte;
    bus_ctrl_t  bus;

    decoder decoder_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_data        (i_data),
        .i_state       (state),
        .o_ex          (ex),
        .o_mode        (mode),
        .o_single_byte (single_byte)
    );

    sequencer sequencer_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ex          (ex),
        .i_mode        (mode),
        .i_single_byte (single_byte),
        .o_state       (state),
        .o_bus         (bus)
    );

    datapath #(
        .BOOT_ADDR (BOOT_ADDR)
    ) datapath_i (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_data (i_data),
        .i_bus  (bus),
        .o_addr (o_addr),
        .o_dout (o_dout),
        .o_rw   (o_rw)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;     // 20 ns period
    end

    // reset held over the first 8 rising edges
    initial begin
        o_rst = 1'b1;
        repeat (8) @(posedge o_clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

//--- test/cpu_chk.sv
`timescale 1ns/1ps

module cpu_test_chk (
    input  logic               i_clk,
    input  logic               i_rst,
    input  cpu_pkg::state_e    i_state,
    input  cpu_pkg::bus_ctrl_t i_bus
);
    import cpu_pkg::*;

    logic store_cycle;

    assign store_cycle = (i_state == T2_ZPG) || (i_state == T3_ABS);

    // memory write only in the last cycle of a store
    strobe_in_store: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_bus.res_dst == DST_MEM) |-> store_cycle)
        else $error("write strobe outside T2_ZPG and T3_ABS");

    fetch_then_decode: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_state == T0_FETCH) |=> (i_state == T1_DECODE))
        else $error("T0_FETCH not followed by T1_DECODE");

    no_jam: assert property (@(posedge i_clk) disable iff (i_rst) i_state != T_JAM)
        else $error("core jammed on an undefined opcode");

endmodule

bind sequencer cpu_test_chk cpu_test_chk_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_state (state),
    .i_bus   (o_bus)
);

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam logic [15:0] BOOT_ADDR   = 16'h0000;
    localparam logic [15:0] PROG_ADDR   = 16'h0400;
    localparam int          NUM_INSTR   = 200;
    localparam int          REF_LIMIT   = 5000;
    localparam int          RESET_LIMIT = 40;
    localparam int          WAIT_LIMIT  = 2000;

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic [7:0]  rdata;
    logic [7:0]  wdata;
    logic        rw;

    logic [7:0]  mem [0:65535];         // memory seen by the dut
    logic [7:0]  model_mem [0:65535];   // program image, then reference memory
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    logic [31:0] lfsr;
    logic [15:0] gen_pc;
    logic [15:0] end_addr;              // address of the final self jump

    tb_clock clock_i (
        .o_clk (clk),
        .o_rst (rst)
    );

    cpu_top #(
        .BOOT_ADDR (BOOT_ADDR)
    ) cpu_top_i (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_data (rdata),
        .o_addr (addr),
        .o_dout (wdata),
        .o_rw   (rw)
    );

    assign rdata = mem[addr];   // combinational read

    always @(posedge clk) begin
        if (!rw) begin
            mem[addr] <= wdata;
        end
    end

    // galois form, taps of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        int         k;
        v = 8'h00;
        for (k = 0; k < n; k++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic emit(input logic [7:0] b);
        model_mem[gen_pc] = b;
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic emit_abs(input logic [7:0] op, input logic [15:0] a);
        emit(op);
        emit(a[7:0]);
        emit(a[15:8]);
    endtask

    // stores go to zp 80-ff and page 20, loads may read any data byte
    task automatic emit_operand(input logic store, input logic [1:0] mode);
        logic [7:0] b;
        logic [7:0] hi;
        case (mode)
            2'd1: begin
                b = store ? (8'h80 | take_bits(7)) : take_bits(8);
                if (b < 8'h10) b = b + 8'h10;
                emit(b);
            end
            2'd2: emit(take_bits(8));
            default: begin
                emit(take_bits(8));
                hi = take_bits(1) ? 8'h20 : 8'h10;
                if (store) hi = 8'h20;
                emit(hi);
            end
        endcase
    endtask

    task automatic build_program();
        int          i;
        int          n;
        logic [3:0]  kind;
        logic [2:0]  oper;
        logic [1:0]  mode;
        logic [1:0]  gap;
        logic [15:0] target;

        for (i = 0; i < 65536; i++) begin
            model_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        for (i = 0; i < 256; i++) begin
            if (i >= 16) model_mem[i] = take_bits(8);
            model_mem[16'h1000 + i] = take_bits(8);
            model_mem[16'h2000 + i] = take_bits(8);
        end

        gen_pc = BOOT_ADDR;
        emit_abs(8'h4c, PROG_ADDR);     // keeps the zero page free for data
        gen_pc = PROG_ADDR;
        for (n = 0; n < NUM_INSTR; n++) begin
            kind = 4'(take_bits(4));
            case (kind)
                4'd0: emit(8'h18);      // clc
                4'd1: emit(8'h38);      // sec
                4'd2: emit(8'hea);      // nop
                4'd3: begin
                    gap    = 2'(take_bits(2));
                    target = gen_pc + 16'd3 + 16'(gap);
                    emit_abs(8'h4c, target);
                    while (gen_pc != target) begin
                        emit(8'h02);    // jams if ever executed
                    end
                end
                default: begin
                    oper = (kind < 4'd8) ? 3'd4 : 3'(take_bits(3));
                    mode = 2'(take_bits(2));
                    if (mode == 2'd0) mode = 2'd2;
                    if (oper == 3'd4 && mode == 2'd2) mode = 2'd1;  // no sta #imm
                    emit({oper, 1'b0, mode, 2'b01});
                    emit_operand(oper == 3'd4, mode);
                end
            endcase
        end

        emit_abs(8'h8d, 16'h20fe);      // final A
        emit(8'ha9);                    // lda #0
        emit(8'h00);
        emit(8'h69);                    // adc #0 leaves C in A
        emit(8'h00);
        emit_abs(8'h8d, 16'h20ff);
        end_addr = gen_pc;
        emit_abs(8'h4c, end_addr);
    endtask

    // instruction level model of A, C and memory, fills the store list
    function automatic int run_reference(input logic [15:0] start);
        logic [15:0] pc;
        logic [15:0] ea;
        logic [7:0]  op;
        logic [7:0]  m;
        logic [7:0]  acc;
        logic        c;
        logic [8:0]  sum;
        int          step;

        pc  = start;
        acc = 8'h00;
        c   = 1'b0;
        for (step = 0; step < REF_LIMIT; step++) begin
            op = model_mem[pc];
            ea = {model_mem[pc + 16'd2], model_mem[pc + 16'd1]};
            if (op == 8'h4c) begin
                if (ea == pc) begin
                    return exp_addr.size();
                end
                pc = ea;
            end else if (op == 8'h18 || op == 8'h38 || op == 8'hea) begin
                if (op == 8'h18) c = 1'b0;
                if (op == 8'h38) c = 1'b1;
                pc = pc + 16'd1;
            end else if (op[1:0] == 2'b01 && op[4:2] >= 3'd1 && op[4:2] <= 3'd3) begin
                case (op[4:2])
                    3'd1: ea = {8'h00, model_mem[pc + 16'd1]};
                    3'd2: ea = pc + 16'd1;      // operand byte itself
                    default: begin
                    end
                endcase
                pc = pc + ((op[4:2] == 3'd3) ? 16'd3 : 16'd2);
                m  = model_mem[ea];
                case (op[7:5])
                    3'd0: acc = acc | m;
                    3'd1: acc = acc & m;
                    3'd2: acc = acc ^ m;
                    3'd3: begin
                        sum = {1'b0, acc} + {1'b0, m} + {8'h00, c};
                        acc = sum[7:0];
                        c   = sum[8];
                    end
                    3'd4: begin
                        model_mem[ea] = acc;
                        exp_addr.push_back(ea);
                        exp_data.push_back(acc);
                    end
                    3'd5: acc = m;
                    3'd6: c = (acc >= m);       // A untouched
                    default: begin
                        sum = {1'b0, acc} + {1'b0, ~m} + {8'h00, c};
                        acc = sum[7:0];
                        c   = sum[8];
                    end
                endcase
            end else begin
                return -1;
            end
        end
        return -1;
    endfunction

    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    initial begin
        int i;
        int cycles;
        int n_seen;
        logic done;

        lfsr = 32'h2791;
        build_program();
        for (i = 0; i < 65536; i++) begin
            mem[i] <= model_mem[i];
        end
        if (run_reference(BOOT_ADDR) < 0) begin
            $display("reference model ran off the program");
            end_with_failure();
        end

        cycles = 0;
        do begin
            @(negedge clk);
            check_value("rw during reset", 16'(rw), 16'd1);
            cycles++;
            if (cycles > RESET_LIMIT) begin
                $display("reset was never released");
                end_with_failure();
            end
        end while (rst);

        // first fetch one cycle after release
        @(posedge clk);
        @(negedge clk);
        check_value("first fetch address", addr, BOOT_ADDR);

        n_seen = 0;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (!rw) begin
                if (n_seen >= exp_addr.size()) begin
                    $display("store to %h beyond the expected stores", addr);
                    end_with_failure();
                end else begin
                    check_value("store address", addr, exp_addr[n_seen]);
                    check_value("store data", 16'(wdata), 16'(exp_data[n_seen]));
                    n_seen++;
                    cycles = 0;
                end
            end else if (addr == end_addr) begin
                done = 1'b1;
            end
            if (cycles > WAIT_LIMIT) begin
                $display("timeout waiting for a store or the final jump");
                end_with_failure();
            end
        end

        if (n_seen == exp_addr.size()) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d stores seen at the final jump", n_seen,
                     exp_addr.size());
            end_with_failure();
        end
    end

endmodule

//--- list.f
rtl/isa_pkg.sv
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/decoder.sv
rtl/sequencer.sv
rtl/datapath.sv
rtl/cpu_top.sv
test/tb_clock.sv
test/cpu_chk.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cpu testbench with verilator
set -u

if ! cd "$(dirname "$0")"; then
    echo "cannot enter the project directory"
    exit 1
fi

build_dir=obj_dir
log=sim.log

if ! verilator --binary --timing --assert -f list.f --top-module tb_top \
        --Mdir "$build_dir" -o tb_top_sim; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_top_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "^Result: PASSED$" "$log"; then
    exit 0
fi
exit 1
